//--- source/exu_config.svh
// sizing macros for the execute cluster, include in any file that needs lane count or width
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// parallel execute lanes per bundle, 2, 4 or 8
`define EXU_LANES 4

// integer data width for operands, pcs and results
`define EXU_XLEN 64

`endif

//--- source/isa_pkg.sv
// RV64 instruction word formats and opcode and funct3 encodings, imported by the decoder
package isa_pkg;

  // register-register format
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // immediate format, also used by jalr
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // branch format with its scattered offset bits
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    b_fmt_t b;
  } inst_u;

  localparam logic [6:0] OP        = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_32     = 7'b0111011;
  localparam logic [6:0] OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] BRANCH    = 7'b1100011;
  localparam logic [6:0] JALR      = 7'b1100111;

  // alu funct3, shifts right share one code
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

//--- source/exu_pkg.sv
// execute cluster types for issue slots, decoded lane requests and lane results
`include "exu_config.svh"

package exu_pkg;

  // LINK hands back pc plus 4 for jalr
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR,
    ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LINK
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
  } br_kind_e;

  // one instruction slot of an issue bundle
  typedef struct packed {
    isa_pkg::inst_u        inst;
    logic [`EXU_XLEN-1:0]  pc;
    logic [`EXU_XLEN-1:0]  rs1;
    logic [`EXU_XLEN-1:0]  rs2;
  } slot_t;

  typedef struct packed {
    logic                  valid;
    logic [`EXU_XLEN-1:0]  pc;
    logic [`EXU_XLEN-1:0]  rs1;
    logic [`EXU_XLEN-1:0]  rs2;
    logic [`EXU_XLEN-1:0]  imm;
    logic                  b_is_imm;
    logic                  word_cut;
    alu_op_e               alu_op;
    br_kind_e              br_kind;
    logic                  illegal;
  } lane_req_t;

  typedef struct packed {
    logic                  valid;
    logic [`EXU_XLEN-1:0]  result;
    logic                  taken;
    logic [`EXU_XLEN-1:0]  target;
    logic                  illegal;
  } lane_res_t;

endpackage

//--- source/issue_decode.sv
// issue stage of the execute cluster, decodes each bundle slot into a registered lane request
`include "exu_config.svh"

module issue_decode (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_valid,
  input  exu_pkg::slot_t     i_slots [`EXU_LANES],
  output exu_pkg::lane_req_t o_req [`EXU_LANES]
);

  import isa_pkg::*;
  import exu_pkg::*;

  localparam int LANES = `EXU_LANES;
  localparam int XLEN  = `EXU_XLEN;

  lane_req_t req_d [LANES];

  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      F3_AND:  op = ALU_AND;
      default: op = ALU_ADD;
    endcase
    return op;
  endfunction

  function automatic lane_req_t decode_slot(input slot_t s, input logic v);
    lane_req_t r;
    inst_u     w;
    logic      word;
    logic      alt_ok;
    w = s.inst;
    word = 1'b0;
    r = '0;
    r.valid = v;
    r.pc = s.pc;
    r.rs1 = s.rs1;
    r.rs2 = s.rs2;
    r.alu_op = ALU_ADD;
    r.br_kind = BR_NONE;
    case (w.r.opcode)
      OP, OP_32: begin
        word = (w.r.opcode == OP_32);
        r.alu_op = alu_from_f3(w.r.funct3, w.r.funct7[5]);
        // only add/sub and the right shifts have an alternate funct7
        alt_ok = (w.r.funct3 == F3_ADD) || (w.r.funct3 == F3_SR);
        r.illegal = !((w.r.funct7 == 7'b0000000) || (alt_ok && w.r.funct7 == 7'b0100000))
                    || (word && !(w.r.funct3 inside {F3_ADD, F3_SLL, F3_SR}));
      end
      OP_IMM, OP_IMM_32: begin
        word = (w.i.opcode == OP_IMM_32);
        r.b_is_imm = 1'b1;
        r.imm = {{(XLEN-12){w.i.imm12[11]}}, w.i.imm12};
        r.alu_op = alu_from_f3(w.i.funct3, (w.i.funct3 == F3_SR) && w.i.imm12[10]);
        // shamt is 6 bits, 5 for the word forms
        case (w.i.funct3)
          F3_ADD:  r.illegal = 1'b0;
          F3_SLL:  r.illegal = word ? |w.i.imm12[11:5] : |w.i.imm12[11:6];
          F3_SR:   r.illegal = word ? |(w.i.imm12[11:5] & 7'b1011111)
                                    : |(w.i.imm12[11:6] & 6'b101111);
          default: r.illegal = word;
        endcase
      end
      BRANCH: begin
        r.imm = {{(XLEN-13){w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
        r.alu_op = ALU_SUB;
        case (w.b.funct3)
          F3_BEQ:  r.br_kind = BR_EQ;
          F3_BNE:  r.br_kind = BR_NE;
          F3_BLT:  r.br_kind = BR_LT;
          F3_BGE:  r.br_kind = BR_GE;
          F3_BLTU: r.br_kind = BR_LTU;
          F3_BGEU: r.br_kind = BR_GEU;
          default: r.illegal = 1'b1;
        endcase
      end
      JALR: begin
        r.b_is_imm = 1'b1;
        r.imm = {{(XLEN-12){w.i.imm12[11]}}, w.i.imm12};
        r.alu_op = ALU_LINK;
        r.illegal = (w.i.funct3 != 3'b000);
        // a malformed jalr never redirects
        if (!r.illegal) begin
          r.br_kind = BR_JUMP;
        end
      end
      default: r.illegal = 1'b1;
    endcase
    r.word_cut = word;
    return r;
  endfunction

  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      req_d[k] = decode_slot(i_slots[k], i_valid);
    end
  end

  always_ff @(posedge i_clk) begin
    for (int k = 0; k < LANES; k++) begin
      if (i_rst) begin
        o_req[k].valid <= 1'b0;
      end else begin
        o_req[k] <= req_d[k];
      end
    end
  end

  for (genvar k = 0; k < LANES; k++) begin : g_chk
    a_illegal_no_branch: assert property (@(posedge i_clk) disable iff (i_rst)
      o_req[k].valid && o_req[k].illegal |-> o_req[k].br_kind == BR_NONE);
  end

endmodule

//--- source/exec_lane.sv
// one RV64 integer execute lane, computes ALU result and branch outcome with a registered output
`include "exu_config.svh"

module exec_lane (
  input  logic               i_clk,
  input  logic               i_rst,
  input  exu_pkg::lane_req_t i_req,
  output exu_pkg::lane_res_t o_res
);

  import exu_pkg::*;

  localparam int XLEN = `EXU_XLEN;

  lane_res_t       res_d;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] diff;
  logic            carry;
  logic            ovf;
  logic            lt_s;
  logic            lt_u;
  logic            eq;
  logic [5:0]      shamt;
  logic [XLEN-1:0] alu;
  logic            taken;

  function automatic logic [XLEN-1:0] sext32(input logic [XLEN-1:0] v);
    return {{(XLEN-32){v[31]}}, v[31:0]};
  endfunction

  // word ops only see the low half of each operand
  always_comb begin
    op_a = i_req.word_cut ? sext32(i_req.rs1) : i_req.rs1;
    op_b = i_req.b_is_imm ? i_req.imm : i_req.rs2;
    if (i_req.word_cut) begin
      op_b = sext32(op_b);
    end
  end

  assign sum = op_a + op_b;

  // a - b as a + ~b + 1, carry out high means no borrow
  assign {carry, diff} = {1'b0, op_a} + {1'b0, ~op_b} + 1'b1;

  // overflow when signs differ and the difference takes the sign of b
  assign ovf   = (op_a[XLEN-1] ^ op_b[XLEN-1]) & (op_a[XLEN-1] ^ diff[XLEN-1]);
  assign lt_s  = diff[XLEN-1] ^ ovf;
  assign lt_u  = ~carry;
  assign eq    = (diff == '0);
  assign shamt = i_req.word_cut ? {1'b0, op_b[4:0]} : op_b[5:0];

  always_comb begin
    case (i_req.alu_op)
      ALU_ADD:  alu = sum;
      ALU_SUB:  alu = diff;
      ALU_SLT:  alu = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: alu = {{(XLEN-1){1'b0}}, lt_u};
      ALU_XOR:  alu = op_a ^ op_b;
      ALU_OR:   alu = op_a | op_b;
      ALU_AND:  alu = op_a & op_b;
      ALU_SLL:  alu = op_a << shamt;
      // srlw shifts zeros into bit 31, not copies of the sign
      ALU_SRL:  alu = (i_req.word_cut ? {{(XLEN-32){1'b0}}, op_a[31:0]} : op_a) >> shamt;
      ALU_SRA:  alu = $signed(op_a) >>> shamt;
      ALU_LINK: alu = i_req.pc + XLEN'(4);
      default:  alu = '0;
    endcase
  end

  always_comb begin
    case (i_req.br_kind)
      BR_EQ:   taken = eq;
      BR_NE:   taken = ~eq;
      BR_LT:   taken = lt_s;
      BR_GE:   taken = ~lt_s;
      BR_LTU:  taken = lt_u;
      BR_GEU:  taken = ~lt_u;
      BR_JUMP: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    res_d.valid   = i_req.valid;
    res_d.illegal = i_req.illegal;
    res_d.taken   = i_req.valid & taken;
    res_d.result  = i_req.illegal ? '0 : (i_req.word_cut ? sext32(alu) : alu);
    // jalr target is rs1 plus imm with bit 0 dropped
    res_d.target  = (i_req.br_kind == BR_JUMP) ? {sum[XLEN-1:1], 1'b0}
                                               : i_req.pc + i_req.imm;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_res.valid <= 1'b0;
      o_res.taken <= 1'b0;
    end else begin
      o_res <= res_d;
    end
  end

  // a taken result comes from a valid branch or jump seen the cycle before
  a_taken_valid: assert property (@(posedge i_clk) disable iff (i_rst)
    o_res.taken |-> o_res.valid && $past(i_req.br_kind) != BR_NONE);

endmodule

//--- source/retire_merge.sv
// retire stage of the execute cluster, picks the oldest taken branch and squashes younger lanes
`include "exu_config.svh"

module retire_merge (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  exu_pkg::lane_res_t   i_res [`EXU_LANES],
  output logic                 o_valid,
  output exu_pkg::lane_res_t   o_res [`EXU_LANES],
  output logic                 o_redirect,
  output logic [`EXU_XLEN-1:0] o_redirect_pc
);

  import exu_pkg::*;

  localparam int LANES = `EXU_LANES;
  localparam int XLEN  = `EXU_XLEN;

  lane_res_t       res_d [LANES];
  logic            any_valid;
  logic            found;
  logic [XLEN-1:0] redir_pc;

  // lane 0 is oldest so the first taken lane wins
  always_comb begin
    any_valid = 1'b0;
    found = 1'b0;
    redir_pc = '0;
    for (int k = 0; k < LANES; k++) begin
      res_d[k] = i_res[k];
      any_valid = any_valid | i_res[k].valid;
      if (found) begin
        res_d[k].valid = 1'b0;
        res_d[k].taken = 1'b0;
      end else if (i_res[k].valid && i_res[k].taken) begin
        found = 1'b1;
        redir_pc = i_res[k].target;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
      o_redirect <= 1'b0;
      for (int k = 0; k < LANES; k++) begin
        o_res[k].valid <= 1'b0;
        o_res[k].taken <= 1'b0;
      end
    end else begin
      o_valid <= any_valid;
      o_redirect <= found;
      o_redirect_pc <= redir_pc;
      o_res <= res_d;
    end
  end

  // redirect only ever leaves with a retiring bundle
  a_redirect_valid: assert property (@(posedge i_clk) disable iff (i_rst)
    o_redirect |-> o_valid);

endmodule

//--- source/exu_cluster.sv
// top of the multi-lane RV64 execute cluster, decode then parallel lanes then retire merge
`include "exu_config.svh"

module exu_cluster (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_valid,
  input  exu_pkg::slot_t       i_slots [`EXU_LANES],
  output logic                 o_valid,
  output exu_pkg::lane_res_t   o_res [`EXU_LANES],
  output logic                 o_redirect,
  output logic [`EXU_XLEN-1:0] o_redirect_pc
);

  import exu_pkg::*;

  localparam int LANES = `EXU_LANES;

  lane_req_t req [LANES];
  lane_res_t res [LANES];

  // stage 1, bundle decode
  issue_decode u_decode (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_slots (i_slots),
    .o_req   (req)
  );

  // stage 2, one lane per slot
  for (genvar k = 0; k < LANES; k++) begin : g_lane
    exec_lane u_lane (
      .i_clk (i_clk),
      .i_rst (i_rst),
      .i_req (req[k]),
      .o_res (res[k])
    );
  end

  // stage 3, redirect and squash
  retire_merge u_merge (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_res         (res),
    .o_valid       (o_valid),
    .o_res         (o_res),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc)
  );

endmodule

//--- tb/tb_exu_cluster.sv
// testbench for exu_cluster, random bundles checked against a reference model of the ISA rules
`include "exu_config.svh"

module tb_exu_cluster;

  timeunit 1ns;
  timeprecision 1ps;

  import isa_pkg::*;
  import exu_pkg::*;

  localparam int LANES     = `EXU_LANES;
  localparam int XLEN      = `EXU_XLEN;
  localparam int RST_CYC   = 8;
  localparam int IDLE_CYC  = 10;
  localparam int N_BUNDLES = 150;
  localparam int LIMIT     = RST_CYC + IDLE_CYC + N_BUNDLES + 6 * 6 + 3 + 50;

  // expected retire bundle, cyc_in is the cycle it was issued
  typedef struct packed {
    logic [LANES-1:0]           valid;
    logic [LANES-1:0]           taken;
    logic [LANES-1:0]           illegal;
    logic [LANES-1:0]           chk_res;
    logic [LANES-1:0]           chk_tgt;
    logic [LANES-1:0][XLEN-1:0] result;
    logic [LANES-1:0][XLEN-1:0] target;
    logic                       redirect;
    logic [XLEN-1:0]            redirect_pc;
    logic [31:0]                cyc_in;
  } exp_t;

  logic            i_clk;
  logic            i_rst;
  logic            i_valid;
  slot_t           i_slots [LANES];
  logic            o_valid;
  lane_res_t       o_res [LANES];
  logic            o_redirect;
  logic [XLEN-1:0] o_redirect_pc;

  logic [31:0] cyc;
  logic [31:0] lcg_state;
  exp_t        exp_q [$];
  int          errors;
  int          checks;

  exu_cluster uut (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_valid       (i_valid),
    .i_slots       (i_slots),
    .o_valid       (o_valid),
    .o_res         (o_res),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc)
  );

  always #20 i_clk = ~i_clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // mostly random, sometimes a boundary value
  function automatic logic [XLEN-1:0] pick_val();
    logic [31:0] r;
    r = lcg_next();
    case (r[30:28])
      3'd0:    return '0;
      3'd1:    return XLEN'(1);
      3'd2:    return '1;
      3'd3:    return {1'b1, {(XLEN-1){1'b0}}};
      3'd4:    return {1'b0, {(XLEN-1){1'b1}}};
      default: return {lcg_next(), lcg_next()};
    endcase
  endfunction

  function automatic logic [XLEN-1:0] sext32(input logic [XLEN-1:0] v);
    return {{(XLEN-32){v[31]}}, v[31:0]};
  endfunction

  function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                              input logic [XLEN-1:0] a_in,
                                              input logic [XLEN-1:0] b_in, input logic word);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] y;
    int              sh;
    a = word ? sext32(a_in) : a_in;
    b = word ? sext32(b_in) : b_in;
    sh = word ? int'(b[4:0]) : int'(b[5:0]);
    case (f3)
      3'd0: y = alt ? a - b : a + b;
      3'd1: y = a << sh;
      3'd2: y = XLEN'($signed(a) < $signed(b));
      3'd3: y = XLEN'(a < b);
      3'd4: y = a ^ b;
      // srlw is a plain 32-bit logical shift
      3'd5: y = alt ? XLEN'($signed(a) >>> sh)
                    : (word ? {{(XLEN-32){1'b0}}, a[31:0] >> sh} : a >> sh);
      3'd6: y = a | b;
      default: y = a & b;
    endcase
    return word ? sext32(y) : y;
  endfunction

  // expected outputs of one bundle, squash applied after the oldest taken lane
  function automatic exp_t model(input slot_t s [LANES]);
    exp_t            e;
    inst_u           w;
    logic [XLEN-1:0] imm;
    logic            tk;
    logic            found;
    e = '0;
    found = 1'b0;
    for (int k = 0; k < LANES; k++) begin
      w = s[k].inst;
      tk = 1'b0;
      e.chk_res[k] = 1'b1;
      imm = {{(XLEN-12){w.i.imm12[11]}}, w.i.imm12};
      case (w.r.opcode)
        OP:        e.result[k] = alu_ref(w.r.funct3, w.r.funct7[5], s[k].rs1, s[k].rs2, 1'b0);
        OP_32:     e.result[k] = alu_ref(w.r.funct3, w.r.funct7[5], s[k].rs1, s[k].rs2, 1'b1);
        OP_IMM:    e.result[k] = alu_ref(w.i.funct3, w.i.funct3 == 3'd5 && w.i.imm12[10],
                                         s[k].rs1, imm, 1'b0);
        OP_IMM_32: e.result[k] = alu_ref(w.i.funct3, w.i.funct3 == 3'd5 && w.i.imm12[10],
                                         s[k].rs1, imm, 1'b1);
        BRANCH: begin
          e.chk_res[k] = 1'b0;
          case (w.b.funct3)
            F3_BEQ:  tk = s[k].rs1 == s[k].rs2;
            F3_BNE:  tk = s[k].rs1 != s[k].rs2;
            F3_BLT:  tk = $signed(s[k].rs1) < $signed(s[k].rs2);
            F3_BGE:  tk = $signed(s[k].rs1) >= $signed(s[k].rs2);
            F3_BLTU: tk = s[k].rs1 < s[k].rs2;
            default: tk = s[k].rs1 >= s[k].rs2;
          endcase
          imm = {{(XLEN-13){w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
          e.chk_tgt[k] = 1'b1;
          e.target[k] = s[k].pc + imm;
          if (tk && !found) begin
            e.redirect_pc = e.target[k];
          end
        end
        JALR: begin
          tk = 1'b1;
          e.result[k] = s[k].pc + XLEN'(4);
          e.chk_tgt[k] = 1'b1;
          e.target[k] = (s[k].rs1 + imm) & ~XLEN'(1);
          if (!found) begin
            e.redirect_pc = e.target[k];
          end
        end
        default: e.illegal[k] = 1'b1;
      endcase
      e.valid[k] = !found;
      e.taken[k] = tk && !found;
      found = found | tk;
    end
    e.redirect = found;
    return e;
  endfunction

  // kind 0 reg, 1 imm, 2 reg word, 3 imm word, 4 branch, 5 jalr, 6 unknown opcode
  function automatic slot_t make_slot(input int kind);
    slot_t       s;
    logic [31:0] r;
    logic [2:0]  f3;
    logic [5:0]  sh;
    logic [12:0] off;
    r = lcg_next();
    s.inst = inst_u'(lcg_next());
    s.pc = {lcg_next(), lcg_next()} & ~XLEN'(3);
    s.rs1 = pick_val();
    s.rs2 = pick_val();
    sh = r[27] ? (r[26] ? 6'd63 : 6'd0) : r[5:0];
    f3 = r[10:8];
    case (kind)
      0, 2: begin
        s.inst.r.opcode = (kind == 2) ? OP_32 : OP;
        if (kind == 2) begin
          f3 = (r[9:8] == 2'd0) ? F3_ADD : (r[9] ? F3_SR : F3_SLL);
        end
        s.inst.r.funct3 = f3;
        s.inst.r.funct7 = (r[11] && (f3 == F3_ADD || f3 == F3_SR)) ? 7'b0100000 : 7'b0;
      end
      1, 3: begin
        s.inst.i.opcode = (kind == 3) ? OP_IMM_32 : OP_IMM;
        if (kind == 3) begin
          f3 = (r[9:8] == 2'd0) ? F3_ADD : (r[9] ? F3_SR : F3_SLL);
          sh[5] = 1'b0;
        end
        s.inst.i.funct3 = f3;
        if (f3 == F3_SLL || f3 == F3_SR) begin
          s.inst.i.imm12 = {1'b0, r[11] && f3 == F3_SR, 4'b0, sh};
        end
      end
      4: begin
        s.inst.b.opcode = BRANCH;
        // the two unused codes fold onto beq and bne
        s.inst.b.funct3 = (f3[2:1] == 2'b01) ? {2'b00, f3[0]} : f3;
        if (r[13:12] == 2'd0) begin
          s.rs2 = s.rs1;
        end
        off = r[25:13];
        {s.inst.b.imm12, s.inst.b.imm11, s.inst.b.imm10_5, s.inst.b.imm4_1} = off[12:1];
      end
      5: begin
        s.inst.i.opcode = JALR;
        s.inst.i.funct3 = 3'd0;
      end
      default: s.inst.r.opcode = 7'b0001011;
    endcase
    return s;
  endfunction

  task automatic send_bundle(input int kind_a, input int kind_b);
    slot_t s [LANES];
    logic [31:0] r;
    exp_t        e;
    int          kind;
    @(negedge i_clk);
    for (int k = 0; k < LANES; k++) begin
      r = lcg_next();
      kind = (kind_a == kind_b) ? kind_a : kind_a + int'(r[20:16]) % (kind_b - kind_a + 1);
      s[k] = make_slot(kind);
    end
    i_slots = s;
    i_valid = 1'b1;
    e = model(s);
    e.cyc_in = cyc;
    exp_q.push_back(e);
  endtask

  // one unknown opcode in a random lane of an otherwise legal bundle
  task automatic send_illegal_bundle();
    slot_t s [LANES];
    int    bad;
    exp_t  e;
    @(negedge i_clk);
    bad = int'(lcg_next() % LANES);
    for (int k = 0; k < LANES; k++) begin
      s[k] = make_slot((k == bad) ? 6 : int'(lcg_next() % 4));
    end
    i_slots = s;
    i_valid = 1'b1;
    e = model(s);
    e.cyc_in = cyc;
    exp_q.push_back(e);
  endtask

  task automatic drain();
    @(negedge i_clk);
    i_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge i_clk);
    end
  endtask

  task automatic check_val(input string name, input int lane, input logic [XLEN-1:0] exp_v,
                           input logic [XLEN-1:0] got_v);
    checks++;
    assert (exp_v == got_v) else begin
      $display("Fail t=%0t %s[%0d] expected %0h got %0h", $time, name, lane, exp_v, got_v);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    $display("test %s done, %0d errors", name, errors - err_start);
  endtask

  always @(posedge i_clk) begin
    cyc <= cyc + 32'd1;
    if (cyc >= 32'(LIMIT)) begin
      $display("timeout, run did not finish within %0d cycles", LIMIT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // compare process, outputs are stable at the falling edge
  always @(negedge i_clk) begin
    exp_t e;
    if (!i_rst && o_valid) begin
      assert (exp_q.size() != 0) else begin
        $display("output valid at t=%0t with no bundle in flight", $time);
        errors++;
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        assert (cyc == e.cyc_in + 32'd3) else begin
          $display("bundle at t=%0t came out %0d cycles after issue", $time, cyc - e.cyc_in);
          errors++;
        end
        for (int k = 0; k < LANES; k++) begin
          check_val("o_res.valid", k, XLEN'(e.valid[k]), XLEN'(o_res[k].valid));
          check_val("o_res.taken", k, XLEN'(e.taken[k]), XLEN'(o_res[k].taken));
          if (e.valid[k]) begin
            check_val("o_res.illegal", k, XLEN'(e.illegal[k]), XLEN'(o_res[k].illegal));
            if (e.chk_res[k]) begin
              check_val("o_res.result", k, e.result[k], o_res[k].result);
            end
            if (e.chk_tgt[k]) begin
              check_val("o_res.target", k, e.target[k], o_res[k].target);
            end
          end
        end
        check_val("o_redirect", 0, XLEN'(e.redirect), XLEN'(o_redirect));
        if (e.redirect) begin
          check_val("o_redirect_pc", 0, e.redirect_pc, o_redirect_pc);
        end
      end
    end else if (!i_rst) begin
      check_val("o_redirect", 0, '0, XLEN'(o_redirect));
    end
  end

  initial begin
    int e0;
    i_clk = 1'b0;
    i_rst = 1'b1;
    i_valid = 1'b0;
    cyc = '0;
    lcg_state = 32'h405111e8;
    errors = 0;
    checks = 0;
    for (int k = 0; k < LANES; k++) begin
      i_slots[k] = '0;
    end
    repeat (RST_CYC) @(negedge i_clk);
    i_rst = 1'b0;

    e0 = errors;
    repeat (IDLE_CYC) @(negedge i_clk);
    finish_test("idle after reset", e0);

    e0 = errors;
    for (int n = 0; n < 40; n++) send_bundle(0, 1);
    drain();
    finish_test("alu ops", e0);

    e0 = errors;
    for (int n = 0; n < 30; n++) send_bundle(2, 3);
    drain();
    finish_test("word ops", e0);

    e0 = errors;
    for (int n = 0; n < 30; n++) send_bundle(4, 5);
    drain();
    finish_test("branches and jalr", e0);

    e0 = errors;
    for (int n = 0; n < 30; n++) send_bundle(0, 5);
    drain();
    finish_test("back to back", e0);

    e0 = errors;
    for (int n = 0; n < 20; n++) send_illegal_bundle();
    drain();
    finish_test("illegal opcodes", e0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+source
source/isa_pkg.sv
source/exu_pkg.sv
source/issue_decode.sv
source/exec_lane.sv
source/retire_merge.sv
source/exu_cluster.sv
tb/tb_exu_cluster.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_exu_cluster
FLIST     = flist.f
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log for the pass line"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

obj_dir/V$(TOP): $(FLIST) $(wildcard source/*.sv source/*.svh tb/*.sv)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
